// File: Bender.yml
package:
  name: fir_core

sources:
  # Package first, then the leaf blocks, then the top level
  - logic/fir_pkg.sv
  - logic/fir_tap_ram.sv
  - logic/fir_delay_line.sv
  - logic/fir_sequencer.sv
  - logic/fir_mac.sv
  - logic/fir_core.sv

  - target: test
    files:
      - testbench/fir_tb.sv

// File: files.f
logic/fir_pkg.sv
logic/fir_tap_ram.sv
logic/fir_delay_line.sv
logic/fir_sequencer.sv
logic/fir_mac.sv
logic/fir_core.sv
testbench/fir_tb.sv

// File: logic/fir_core.sv
// FIR top level, one output beat per input sample of a frame.
// cfg is sampled on start, tap writes are ignored while a frame runs.
`timescale 1ns/1ps
`default_nettype none

module fir_core #(
  parameter int MUL_STAGES = 2
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              start,
  input  fir_pkg::fir_cfg_t                 cfg,
  input  logic                              tap_we,
  input  logic [fir_pkg::TAP_AW-1:0]        tap_addr,
  input  logic signed [fir_pkg::DATA_W-1:0] tap_wdata,
  input  logic                              in_valid,
  input  logic signed [fir_pkg::DATA_W-1:0] in_data,
  input  logic                              out_ready,
  output logic                              done,
  output logic                              in_ready,
  output logic                              out_valid,
  output fir_pkg::fir_beat_t                out_beat
);
  import fir_pkg::*;

  logic                     tap_we_ok;
  logic                     shift_en;
  logic                     clr_en;
  logic [TAP_AW-1:0]        clr_addr;
  logic [TAP_AW-1:0]        rd_addr;
  fir_op_ctl_t              op;
  logic                     op_ready;
  logic signed [DATA_W-1:0] coef;
  logic signed [DATA_W-1:0] sample;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // The MAC's done pulse also returns the sequencer to idle
  fir_sequencer u_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .cfg        (cfg),
    .tap_we     (tap_we),
    .in_valid   (in_valid),
    .op_ready   (op_ready),
    .frame_done (done),
    .tap_we_ok  (tap_we_ok),
    .in_ready   (in_ready),
    .shift_en   (shift_en),
    .clr_en     (clr_en),
    .clr_addr   (clr_addr),
    .rd_addr    (rd_addr),
    .op         (op)
  );

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  fir_tap_ram u_tap_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (tap_we_ok),
    .waddr (tap_addr),
    .wdata (tap_wdata),
    .raddr (rd_addr),
    .coef  (coef)
  );

  fir_delay_line u_delay_line (
    .clk      (clk),
    .rst_n    (rst_n),
    .shift_en (shift_en),
    .din      (in_data),
    .clr_en   (clr_en),
    .clr_addr (clr_addr),
    .raddr    (rd_addr),
    .sample   (sample)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  fir_mac #(
    .MUL_STAGES (MUL_STAGES)
  ) u_mac (
    .clk        (clk),
    .rst_n      (rst_n),
    .op         (op),
    .coef       (coef),
    .sample     (sample),
    .out_ready  (out_ready),
    .op_ready   (op_ready),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .frame_done (done)
  );

endmodule

`default_nettype wire

// File: logic/fir_delay_line.sv
// Sample history, entry k holds the sample from k inputs ago.
// No reset, the clear phase of every frame zeroes the entries that are read.
`timescale 1ns/1ps
`default_nettype none

module fir_delay_line (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              shift_en,
  input  logic signed [fir_pkg::DATA_W-1:0] din,
  input  logic                              clr_en,
  input  logic [fir_pkg::TAP_AW-1:0]        clr_addr,
  input  logic [fir_pkg::TAP_AW-1:0]        raddr,
  output logic signed [fir_pkg::DATA_W-1:0] sample
);
  import fir_pkg::*;

  localparam int DEPTH = 2 ** TAP_AW;

  logic signed [DATA_W-1:0] mem [DEPTH];

  ////////////////////////////////////////
  // Shift and clear
  ////////////////////////////////////////

  // A new sample lands at entry 0 and the oldest entry falls off the top
  // Entries at or above tap_num are never read, so their content does not matter
  always_ff @(posedge clk) begin
    if (shift_en) begin
      mem[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        mem[i] <= mem[i-1];
      end
    end else if (clr_en) begin
      // One entry per cycle during the clear phase
      mem[clr_addr] <= '0;
    end
  end

  ////////////////////////////////////////
  // Read
  ////////////////////////////////////////

  // Asynchronous read at the tap address of the current operation
  assign sample = mem[raddr];

  // Clear only runs in the clear phase and shifting only in calc
  // Both at once would mean the sequencer phases overlap
  a_no_shift_during_clear: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(shift_en && clr_en)
  ) else $error("delay line shifted during clear");

endmodule

`default_nettype wire

// File: logic/fir_mac.sv
// Pipelined signed multiply and accumulate with one output register.
// MUL_STAGES runs from 1 to 4, a full output that is not taken stalls the pipeline.
`timescale 1ns/1ps
`default_nettype none

module fir_mac #(
  parameter int MUL_STAGES = 2
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  fir_pkg::fir_op_ctl_t              op,
  input  logic signed [fir_pkg::DATA_W-1:0] coef,
  input  logic signed [fir_pkg::DATA_W-1:0] sample,
  input  logic                              out_ready,
  output logic                              op_ready,
  output logic                              out_valid,
  output fir_pkg::fir_beat_t                out_beat,
  output logic                              frame_done
);
  import fir_pkg::*;

  localparam int PROD_W = 2 * DATA_W;

  if ((MUL_STAGES < 1) || (MUL_STAGES > 4)) begin : g_bad_stages
    $error("fir_mac: MUL_STAGES must lie between 1 and 4");
  end

  logic signed [PROD_W-1:0] prod;
  logic signed [PROD_W-1:0] prod_q [MUL_STAGES];
  fir_op_ctl_t              ctl_q  [MUL_STAGES];
  fir_op_ctl_t              tail;
  logic signed [ACC_W-1:0]  prod_ext;
  logic signed [ACC_W-1:0]  acc_q;
  logic signed [ACC_W-1:0]  acc_base;
  logic signed [ACC_W-1:0]  acc_sum;
  logic                     sum_done;
  logic                     out_take;
  logic                     stall;

  ////////////////////////////////////////
  // Stall
  ////////////////////////////////////////

  // Only a finished sum needs the output register, partial sums keep flowing
  assign tail     = ctl_q[MUL_STAGES-1];
  assign sum_done = tail.valid && tail.last_tap;
  assign out_take = out_valid && out_ready;
  assign stall    = out_valid && !out_ready && sum_done;
  assign op_ready = !stall;

  ////////////////////////////////////////
  // Multiplier pipeline
  ////////////////////////////////////////

  // Behavioural multiply, the stages after it let synthesis retime the array
  assign prod = coef * sample;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        ctl_q[i] <= '0;
      end
    end else if (!stall) begin
      ctl_q[0] <= op;
      for (int i = 1; i < MUL_STAGES; i++) begin
        ctl_q[i] <= ctl_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      prod_q[0] <= prod;
      for (int i = 1; i < MUL_STAGES; i++) begin
        prod_q[i] <= prod_q[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////

  // Sign extension of the product to the guard bits
  assign prod_ext = {{(ACC_W - PROD_W){prod_q[MUL_STAGES-1][PROD_W-1]}}, prod_q[MUL_STAGES-1]};
  // The first tap drops whatever the previous sum left behind
  assign acc_base = tail.first ? '0 : acc_q;
  assign acc_sum  = acc_base + prod_ext;

  always_ff @(posedge clk) begin
    if (!stall && tail.valid) begin
      acc_q <= acc_sum;
    end
  end

  ////////////////////////////////////////
  // Output register and done
  ////////////////////////////////////////

  // Loads in the same cycle as a transfer, so back to back sums need no bubble
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      if (sum_done && !stall) begin
        out_valid <= 1'b1;
      end else if (out_take) begin
        out_valid <= 1'b0;
      end
      frame_done <= out_take && out_beat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (sum_done && !stall) begin
      out_beat.sum  <= acc_sum;
      out_beat.last <= tail.last_sample;
    end
  end

  // A beat that is offered stays offered and unchanged until it is taken
  a_beat_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_beat)
  ) else $error("out_beat changed under back-pressure");

endmodule

`default_nettype wire

// File: logic/fir_pkg.sv
// Shared widths and types of the FIR core. Samples and coefficients are always signed.
// TAP_AW bounds the tap count to 2**TAP_AW - 1 and COUNT_W bounds the samples per frame.
`default_nettype none

package fir_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Width of one sample and of one coefficient
  parameter int DATA_W = 16;

  // Address width of the tap memory and the delay line
  parameter int TAP_AW = 5;

  // Width of the sample counter, up to 1023 samples in a frame
  parameter int COUNT_W = 10;

  // A full product plus one guard bit per address bit
  // Summing at most 2**TAP_AW - 1 products cannot overflow this width
  parameter int ACC_W = 2 * DATA_W + TAP_AW;

  ////////////////////////////////////////
  // Sequencer phase
  ////////////////////////////////////////

  // Idle accepts tap writes and start, clear wipes the delay line,
  // calc takes samples and issues the multiply operations
  typedef enum logic [1:0] {
    PH_IDLE  = 2'd0,
    PH_CLEAR = 2'd1,
    PH_CALC  = 2'd2
  } fir_phase_e;

  ////////////////////////////////////////
  // Structs between the blocks
  ////////////////////////////////////////

  // Frame configuration, captured by the sequencer on start
  typedef struct packed {
    logic [TAP_AW-1:0]  tap_num;
    logic [COUNT_W-1:0] data_num;
  } fir_cfg_t;

  // Control that travels with one multiply operation
  typedef struct packed {
    // The operation is real, not a bubble
    logic valid;
    // Tap 0, so the accumulator restarts from this product
    logic first;
    // Final tap, so the sum is complete after this product
    logic last_tap;
    // The sum belongs to the final sample of the frame
    logic last_sample;
  } fir_op_ctl_t;

  // One beat on the output stream
  typedef struct packed {
    logic signed [ACC_W-1:0] sum;
    logic                    last;
  } fir_beat_t;

endpackage

`default_nettype wire

// File: logic/fir_sequencer.sv
// Phase control of the FIR core. tap_num and data_num must both be at least 1.
// Tap writes pass only while idle, and the cycle that ends a frame counts as idle.
`timescale 1ns/1ps
`default_nettype none

module fir_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  fir_pkg::fir_cfg_t          cfg,
  input  logic                       tap_we,
  input  logic                       in_valid,
  input  logic                       op_ready,
  input  logic                       frame_done,
  output logic                       tap_we_ok,
  output logic                       in_ready,
  output logic                       shift_en,
  output logic                       clr_en,
  output logic [fir_pkg::TAP_AW-1:0] clr_addr,
  output logic [fir_pkg::TAP_AW-1:0] rd_addr,
  output fir_pkg::fir_op_ctl_t       op
);
  import fir_pkg::*;

  fir_phase_e         phase_q;
  fir_phase_e         phase_d;
  fir_cfg_t           cfg_q;
  logic [TAP_AW-1:0]  clr_cnt;
  logic [TAP_AW-1:0]  tap_cnt;
  logic [COUNT_W-1:0] sample_cnt;
  logic               issuing;
  logic [TAP_AW-1:0]  tap_last;
  logic [COUNT_W-1:0] sample_last;
  logic               idle;
  logic               launch;
  logic               clr_done;
  logic               op_fire;

  assign tap_last    = cfg_q.tap_num - 1'b1;
  assign sample_last = cfg_q.data_num - 1'b1;

  // The done cycle already behaves as idle, so a new start is not lost there
  assign idle     = (phase_q == PH_IDLE) || ((phase_q == PH_CALC) && frame_done);
  assign launch   = idle && start;
  assign clr_done = (phase_q == PH_CLEAR) && (clr_cnt == tap_last);
  assign op_fire  = op.valid && op_ready;

  ////////////////////////////////////////
  // Phase machine
  ////////////////////////////////////////

  always_comb begin
    phase_d = phase_q;
    if (launch) begin
      phase_d = PH_CLEAR;
    end else if (clr_done) begin
      phase_d = PH_CALC;
    end else if ((phase_q == PH_CALC) && frame_done) begin
      phase_d = PH_IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= PH_IDLE;
      cfg_q   <= '0;
      clr_cnt <= '0;
    end else begin
      phase_q <= phase_d;
      if (launch) begin
        cfg_q <= cfg;
      end
      // Counts the clear cycles and parks at zero in every other phase
      if (phase_q == PH_CLEAR) begin
        clr_cnt <= clr_cnt + 1'b1;
      end else begin
        clr_cnt <= '0;
      end
    end
  end

  ////////////////////////////////////////
  // Sample and tap counters
  ////////////////////////////////////////

  // Calc alternates between waiting for a sample and issuing its taps
  // Counters hold in any cycle where the MAC refuses the operation
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issuing    <= 1'b0;
      tap_cnt    <= '0;
      sample_cnt <= '0;
    end else if (launch) begin
      issuing    <= 1'b0;
      tap_cnt    <= '0;
      sample_cnt <= '0;
    end else if (shift_en) begin
      issuing <= 1'b1;
      tap_cnt <= '0;
    end else if (op_fire) begin
      if (op.last_tap) begin
        issuing    <= 1'b0;
        tap_cnt    <= '0;
        sample_cnt <= sample_cnt + 1'b1;
      end else begin
        tap_cnt <= tap_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // No more samples once data_num have been taken in
  assign in_ready = (phase_q == PH_CALC) && !issuing && (sample_cnt != cfg_q.data_num);
  assign shift_en = in_ready && in_valid;

  assign clr_en   = (phase_q == PH_CLEAR);
  assign clr_addr = clr_cnt;

  // Tap k is paired with delay entry k through the shared address
  assign rd_addr = tap_cnt;

  assign op.valid       = (phase_q == PH_CALC) && issuing;
  assign op.first       = (tap_cnt == '0);
  assign op.last_tap    = (tap_cnt == tap_last);
  assign op.last_sample = (sample_cnt == sample_last);

  // The coefficient store may only change while no frame reads it
  assign tap_we_ok = tap_we && idle;

  // A taken sample starts its operations in the next cycle with tap 0
  a_shift_starts_taps: assert property (
    @(posedge clk) disable iff (!rst_n)
    shift_en |=> op.valid && op.first
  ) else $error("sample taken without starting its taps");

  // Every issued operation belongs to a sample that was taken in this frame
  a_op_calc: assert property (
    @(posedge clk) disable iff (!rst_n)
    op.valid |-> (phase_q == PH_CALC) && (sample_cnt < cfg_q.data_num)
  ) else $error("operation issued outside calc");

endmodule

`default_nettype wire

// File: logic/fir_tap_ram.sv
// Coefficient store with a synchronous write and an asynchronous read.
// Every entry clears on reset, so taps never written add nothing to a sum.
`timescale 1ns/1ps
`default_nettype none

module fir_tap_ram (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              we,
  input  logic [fir_pkg::TAP_AW-1:0]        waddr,
  input  logic signed [fir_pkg::DATA_W-1:0] wdata,
  input  logic [fir_pkg::TAP_AW-1:0]        raddr,
  output logic signed [fir_pkg::DATA_W-1:0] coef
);
  import fir_pkg::*;

  localparam int DEPTH = 2 ** TAP_AW;

  // One coefficient per address, built from flops
  logic signed [DATA_W-1:0] mem [DEPTH];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // The write enable arrives already qualified with the idle phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[waddr] <= wdata;
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Combinational read, so the coefficient lines up with the delay line entry
  assign coef = mem[raddr];

endmodule

`default_nettype wire

// File: testbench/fir_tb.sv
// Self-checking testbench for fir_core with random taps, samples and stream stalls.
// Four frames run back to back, with the last two at tap counts of 1 and 31.
`timescale 1ns/1ps
`default_nettype none

module fir_tb;
  import fir_pkg::*;

  localparam int NUM_FRAMES = 4;
  localparam int TAP_DEPTH  = 2 ** TAP_AW;

  logic                     clk;
  logic                     rst_n;
  logic                     start;
  fir_cfg_t                 cfg;
  logic                     tap_we;
  logic [TAP_AW-1:0]        tap_addr;
  logic signed [DATA_W-1:0] tap_wdata;
  logic                     in_valid;
  logic signed [DATA_W-1:0] in_data;
  logic                     out_ready;
  logic                     done;
  logic                     in_ready;
  logic                     out_valid;
  fir_beat_t                out_beat;

  integer seed   = 32'h146b_c1f8;
  int     errors = 0;

  // The second frame changes cfg to show that no history leaks across frames
  int frame_taps    [NUM_FRAMES] = '{8, 13, 1, 31};
  int frame_count   [NUM_FRAMES] = '{24, 30, 16, 12};
  bit frame_extreme [NUM_FRAMES] = '{1'b0, 1'b0, 1'b0, 1'b1};

  // Reference model state with the newest sample at the front of the history
  logic signed [DATA_W-1:0] tap_model [TAP_DEPTH];
  logic signed [DATA_W-1:0] history [$];
  fir_beat_t                expected [$];

  fir_core #(
    .MUL_STAGES (2)
  ) u_fir_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg       (cfg),
    .tap_we    (tap_we),
    .tap_addr  (tap_addr),
    .tap_wdata (tap_wdata),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_ready (out_ready),
    .done      (done),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  // Four cycles per tap slot of every sample leaves room for all stalls
  initial begin : watchdog
    int limit;
    int cycles;
    limit = 100;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      limit += frame_count[f] * (frame_taps[f] + 4) * 4;
    end
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Error: the run hung and did not finish within %0d cycles", limit);
    $display("Checks done, %0d errors", errors + 1);
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////
  // Model and helpers
  ////////////////////////////////////////

  // Extreme mode keeps to the two ends of the signed range and mostly to the negative one
  function automatic logic signed [DATA_W-1:0] pick_value(input bit extreme);
    logic [31:0] rnd;
    rnd = $random(seed);
    if (extreme) begin
      return (rnd[1:0] == 2'd0) ? 16'sh7fff : 16'sh8000;
    end
    return rnd[DATA_W-1:0];
  endfunction

  // Sum over the taps, with samples before the frame taken as zero
  function automatic logic signed [ACC_W-1:0] model_sum(input int taps);
    longint acc;
    acc = 0;
    for (int k = 0; (k < taps) && (k < history.size()); k++) begin
      acc += longint'(tap_model[k]) * longint'(history[k]);
    end
    return acc[ACC_W-1:0];
  endfunction

  task automatic check_bit(input string name, input logic expv, input logic act);
    if (act !== expv) begin
      errors++;
      $display("Error: %0t %s expected %0b got %0b", $time, name, expv, act);
    end
  endtask

  task automatic write_taps(input int taps, input bit extreme);
    logic signed [DATA_W-1:0] v;
    for (int k = 0; k < taps; k++) begin
      @(negedge clk);
      if (extreme) begin
        v = ((k % 5) == 4) ? 16'sh7fff : 16'sh8000;
      end else begin
        v = pick_value(1'b0);
      end
      tap_we       = 1'b1;
      tap_addr     = TAP_AW'(k);
      tap_wdata    = v;
      tap_model[k] = v;
    end
    @(negedge clk);
    tap_we = 1'b0;
  endtask

  ////////////////////////////////////////
  // One frame
  ////////////////////////////////////////

  // Everything is sampled at the falling edge, where DUT outputs have settled
  // in_ready does not depend on in_valid, so a transfer is known before the rising edge
  task automatic run_frame(input int taps, input int count, input bit extreme);
    int                       sent;
    int                       taken;
    bit                       last_due;
    bit                       hold;
    bit                       ending;
    fir_beat_t                held_beat;
    fir_beat_t                exp_beat;
    logic [31:0]              rnd;
    logic signed [DATA_W-1:0] x;
    history.delete();
    expected.delete();
    sent     = 0;
    taken    = 0;
    last_due = 1'b0;
    hold     = 1'b0;
    ending   = 1'b0;
    x        = pick_value(extreme);
    cfg.tap_num  = TAP_AW'(taps);
    cfg.data_num = COUNT_W'(count);
    start        = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!ending) begin
      @(negedge clk);
      // done is due exactly one cycle after the last beat was taken
      check_bit("done", last_due, done);
      if (last_due) begin
        ending = 1'b1;
        check_bit("in_ready", 1'b0, in_ready);
      end
      if (hold) begin
        check_bit("out_valid", 1'b1, out_valid);
        if (out_beat !== held_beat) begin
          errors++;
          $display("Error: %0t out_beat expected %h got %h", $time, held_beat, out_beat);
        end
      end
      if (!ending) begin
        rnd       = $random(seed);
        in_valid  = (sent < count) && (rnd[1:0] != 2'd0);
        in_data   = x;
        out_ready = (rnd[3:2] != 2'd0);
        if (in_valid && in_ready) begin
          history.push_front(x);
          exp_beat.sum  = model_sum(taps);
          exp_beat.last = (sent == count - 1);
          expected.push_back(exp_beat);
          sent++;
          x = pick_value(extreme);
        end
        last_due  = 1'b0;
        hold      = out_valid && !out_ready;
        held_beat = out_beat;
        if (out_valid && out_ready) begin
          if (expected.size() == 0) begin
            errors++;
            $display("Error: %0t a beat came out with no sample left to match it", $time);
          end else begin
            exp_beat = expected.pop_front();
            if (out_beat.sum !== exp_beat.sum) begin
              errors++;
              $display("Error: %0t out_beat.sum expected %0d got %0d",
                       $time, exp_beat.sum, out_beat.sum);
            end
            check_bit("out_beat.last", exp_beat.last, out_beat.last);
            last_due = exp_beat.last;
          end
          taken++;
        end
      end
    end
    in_valid  = 1'b0;
    out_ready = 1'b0;
    // done lasts a single cycle
    @(negedge clk);
    check_bit("done", 1'b0, done);
    if (taken != count) begin
      errors++;
      $display("Error: %0t frame gave %0d beats instead of %0d", $time, taken, count);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : stimulus
    rst_n     = 1'b0;
    start     = 1'b0;
    cfg       = '0;
    tap_we    = 1'b0;
    tap_addr  = '0;
    tap_wdata = '0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("in_ready", 1'b0, in_ready);
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("done", 1'b0, done);
    for (int f = 0; f < NUM_FRAMES; f++) begin
      write_taps(frame_taps[f], frame_extreme[f]);
      run_frame(frame_taps[f], frame_count[f], frame_extreme[f]);
    end
    repeat (4) @(negedge clk);
    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
